// ==== verilog/bridge_pkg.sv ====
package bridge_pkg;

    // bus and line geometry
    localparam int BEAT_W     = 32;
    localparam int LINE_BEATS = 8;
    localparam int LINE_W     = BEAT_W * LINE_BEATS;
    localparam int BEAT_IDX_W = 3;
    localparam int OFFSET_W   = 5;

    typedef enum logic [1:0] {
        SRC_NONE   = 2'b00,
        SRC_ICACHE = 2'b01,
        SRC_DCACHE = 2'b10,
        SRC_UNC    = 2'b11
    } rd_src_e;

    // line number for bursts, word number for single transfers
    typedef union packed {
        struct packed {
            logic [31-OFFSET_W:0] line_num;
            logic [OFFSET_W-1:0]  offset;
        } line_view;
        struct packed {
            logic [29:0] word_num;
            logic [1:0]  byte_sel;
        } word_view;
    } addr_u;

    typedef struct packed {
        logic    valid;
        rd_src_e src;
        addr_u   addr;
    } rd_desc_t;

    // uncached word sits in the lowest beat of data
    typedef struct packed {
        logic              valid;
        logic              uncached;
        addr_u             addr;
        logic [3:0]        strb;
        logic [LINE_W-1:0] data;
    } wr_desc_t;

    typedef struct packed {
        logic                  valid;
        rd_src_e               src;
        logic [BEAT_IDX_W-1:0] idx;
        logic [BEAT_W-1:0]     data;
    } rd_beat_t;

endpackage

// ==== verilog/req_decode.sv ====
`timescale 1ns/1ps

module req_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inst_ren_i,
    input  logic [31:0]                   inst_addr_i,
    input  logic                          data_ren_i,
    input  logic [31:0]                   data_raddr_i,
    input  logic                          data_wen_i,
    input  logic [31:0]                   data_waddr_i,
    input  logic [bridge_pkg::LINE_W-1:0] data_wdata_i,
    input  logic                          unc_ren_i,
    input  logic [31:0]                   unc_raddr_i,
    input  logic                          unc_wen_i,
    input  logic [31:0]                   unc_waddr_i,
    input  logic [bridge_pkg::BEAT_W-1:0] unc_wdata_i,
    input  logic [3:0]                    unc_wstrb_i,
    input  logic                          rd_busy_i,
    input  logic                          rd_done_i,
    input  logic                          wr_busy_i,
    input  logic                          wr_done_i,
    output logic                          inst_accept_o,
    output logic                          data_raccept_o,
    output logic                          data_waccept_o,
    output logic                          unc_raccept_o,
    output logic                          unc_waccept_o,
    output bridge_pkg::rd_desc_t          rd_desc_o,
    output bridge_pkg::wr_desc_t          wr_desc_o
);
    import bridge_pkg::*;

    logic     rd_free;
    logic     wr_free;
    rd_desc_t rd_desc_q;
    wr_desc_t wr_desc_q;

    // cached requests go out line aligned
    function automatic addr_u line_addr(input logic [31:0] a);
        addr_u r;
        r.line_view.line_num = a[31:OFFSET_W];
        r.line_view.offset   = '0;
        return r;
    endfunction

    function automatic addr_u word_addr(input logic [31:0] a);
        addr_u r;
        r.word_view.word_num = a[31:2];
        r.word_view.byte_sel = a[1:0];
        return r;
    endfunction

    assign rd_free = !rd_desc_q.valid && !rd_busy_i;
    assign wr_free = !wr_desc_q.valid && !wr_busy_i;

    // read priority: uncached, dcache, icache
    assign unc_raccept_o  = rd_free && unc_ren_i;
    assign data_raccept_o = rd_free && data_ren_i && !unc_ren_i;
    assign inst_accept_o  = rd_free && inst_ren_i && !unc_ren_i && !data_ren_i;

    assign unc_waccept_o  = wr_free && unc_wen_i;
    assign data_waccept_o = wr_free && data_wen_i && !unc_wen_i;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_desc_q.valid <= 1'b0;
            rd_desc_q.src   <= SRC_NONE;
        end
        else if (rd_done_i)
            rd_desc_q.valid <= 1'b0;
        else if (unc_raccept_o)
            rd_desc_q <= '{valid: 1'b1, src: SRC_UNC, addr: word_addr(unc_raddr_i)};
        else if (data_raccept_o)
            rd_desc_q <= '{valid: 1'b1, src: SRC_DCACHE, addr: line_addr(data_raddr_i)};
        else if (inst_accept_o)
            rd_desc_q <= '{valid: 1'b1, src: SRC_ICACHE, addr: line_addr(inst_addr_i)};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            wr_desc_q.valid <= 1'b0;
        else if (wr_done_i)
            wr_desc_q.valid <= 1'b0;
        else if (unc_waccept_o)
            wr_desc_q <= '{valid: 1'b1, uncached: 1'b1, addr: word_addr(unc_waddr_i),
                           strb: unc_wstrb_i, data: LINE_W'(unc_wdata_i)};
        else if (data_waccept_o)
            wr_desc_q <= '{valid: 1'b1, uncached: 1'b0, addr: line_addr(data_waddr_i),
                           strb: 4'hf, data: data_wdata_i};
    end

    assign rd_desc_o = rd_desc_q;
    assign wr_desc_o = wr_desc_q;

    // held until the engine reports done
    a_rd_desc_stable: assert property (@(posedge clk) disable iff (rst)
        rd_desc_q.valid && !rd_done_i |=> $stable(rd_desc_q));
    a_wr_desc_stable: assert property (@(posedge clk) disable iff (rst)
        wr_desc_q.valid && !wr_done_i |=> $stable(wr_desc_q));

endmodule

// ==== verilog/read_burst_engine.sv ====
`timescale 1ns/1ps

module read_burst_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  bridge_pkg::rd_desc_t          rd_desc_i,
    input  logic                          bus_rvalid_i,
    input  logic [bridge_pkg::BEAT_W-1:0] bus_rdata_i,
    output logic                          rd_busy_o,
    output logic                          rd_done_o,
    output bridge_pkg::rd_beat_t          rd_beat_o,
    output logic                          bus_ren_o,
    output logic [31:0]                   bus_raddr_o,
    output logic [7:0]                    bus_rlen_o
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_LINE,
        RD_WORD
    } rd_state_e;

    rd_state_e             state_q;
    logic [BEAT_IDX_W-1:0] beat_cnt_q;
    logic                  last_beat;

    assign last_beat = (state_q == RD_WORD) ||
                       (beat_cnt_q == BEAT_IDX_W'(LINE_BEATS - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q    <= RD_IDLE;
            beat_cnt_q <= '0;
        end
        else
        begin
            case (state_q)
                RD_IDLE:
                begin
                    beat_cnt_q <= '0;
                    if (rd_desc_i.valid)
                        state_q <= (rd_desc_i.src == SRC_UNC) ? RD_WORD : RD_LINE;
                end
                default:
                begin
                    if (bus_rvalid_i)
                    begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (last_beat)
                            state_q <= RD_IDLE;
                    end
                end
            endcase
        end
    end

    assign rd_busy_o = (state_q != RD_IDLE);
    assign rd_done_o = rd_busy_o && bus_rvalid_i && last_beat;

    // address and length stay put while the descriptor is held
    assign bus_ren_o   = rd_busy_o;
    assign bus_raddr_o = rd_desc_i.addr;
    assign bus_rlen_o  = (state_q == RD_WORD) ? 8'd0 : 8'(LINE_BEATS - 1);

    // tag each beat with owner and position
    assign rd_beat_o.valid = rd_busy_o && bus_rvalid_i;
    assign rd_beat_o.src   = rd_busy_o ? rd_desc_i.src : SRC_NONE;
    assign rd_beat_o.idx   = beat_cnt_q;
    assign rd_beat_o.data  = bus_rdata_i;

    a_no_rvalid_idle: assert property (@(posedge clk) disable iff (rst)
        state_q == RD_IDLE |-> !bus_rvalid_i);

endmodule

// ==== verilog/write_burst_engine.sv ====
`timescale 1ns/1ps

module write_burst_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  bridge_pkg::wr_desc_t          wr_desc_i,
    input  logic                          bus_wresp_i,
    output logic                          wr_busy_o,
    output logic                          wr_done_o,
    output logic                          bus_wen_o,
    output logic [31:0]                   bus_waddr_o,
    output logic [bridge_pkg::BEAT_W-1:0] bus_wdata_o,
    output logic [3:0]                    bus_wstrb_o,
    output logic [7:0]                    bus_wlen_o,
    output logic                          bus_wlast_o
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_LINE,
        WR_WORD
    } wr_state_e;

    wr_state_e             state_q;
    logic [BEAT_IDX_W-1:0] beat_cnt_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q    <= WR_IDLE;
            beat_cnt_q <= '0;
        end
        else
        begin
            case (state_q)
                WR_IDLE:
                begin
                    beat_cnt_q <= '0;
                    if (wr_desc_i.valid)
                        state_q <= wr_desc_i.uncached ? WR_WORD : WR_LINE;
                end
                default:
                begin
                    // each response moves on to the next beat
                    if (bus_wresp_i)
                    begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (bus_wlast_o)
                            state_q <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    // uncached word sits in beat 0, and the count stays zero for it
    assign bus_wdata_o = wr_desc_i.data[beat_cnt_q*BEAT_W +: BEAT_W];

    assign wr_busy_o   = (state_q != WR_IDLE);
    assign bus_wen_o   = wr_busy_o;
    assign bus_waddr_o = wr_desc_i.addr;
    assign bus_wstrb_o = (state_q == WR_WORD) ? wr_desc_i.strb : 4'hf;
    assign bus_wlen_o  = (state_q == WR_WORD) ? 8'd0 : 8'(LINE_BEATS - 1);
    assign bus_wlast_o = (state_q == WR_WORD) ||
                         (state_q == WR_LINE && beat_cnt_q == BEAT_IDX_W'(LINE_BEATS - 1));
    assign wr_done_o   = bus_wresp_i && bus_wlast_o;

    a_no_wresp_idle: assert property (@(posedge clk) disable iff (rst)
        state_q == WR_IDLE |-> !bus_wresp_i);

endmodule

// ==== verilog/line_assembler.sv ====
`timescale 1ns/1ps

module line_assembler (
    input  logic                          clk,
    input  logic                          rst,
    input  bridge_pkg::rd_beat_t          rd_beat_i,
    input  logic                          rd_done_i,
    input  logic                          wr_done_i,
    input  logic                          wr_uncached_i,
    output logic                          inst_rvalid_o,
    output logic [bridge_pkg::LINE_W-1:0] inst_rdata_o,
    output logic                          data_rvalid_o,
    output logic [bridge_pkg::LINE_W-1:0] data_rdata_o,
    output logic                          unc_rvalid_o,
    output logic [bridge_pkg::BEAT_W-1:0] unc_rdata_o,
    output logic                          data_bvalid_o,
    output logic                          unc_bvalid_o
);
    import bridge_pkg::*;

    // beat 0 lands in the low bits
    always_ff @(posedge clk)
    begin
        if (rd_beat_i.valid)
        begin
            case (rd_beat_i.src)
                SRC_ICACHE: inst_rdata_o[rd_beat_i.idx*BEAT_W +: BEAT_W] <= rd_beat_i.data;
                SRC_DCACHE: data_rdata_o[rd_beat_i.idx*BEAT_W +: BEAT_W] <= rd_beat_i.data;
                SRC_UNC:    unc_rdata_o <= rd_beat_i.data;
                default:    ;
            endcase
        end
    end

    // one cycle after the closing beat or response
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            inst_rvalid_o <= 1'b0;
            data_rvalid_o <= 1'b0;
            unc_rvalid_o  <= 1'b0;
            data_bvalid_o <= 1'b0;
            unc_bvalid_o  <= 1'b0;
        end
        else
        begin
            inst_rvalid_o <= rd_done_i && (rd_beat_i.src == SRC_ICACHE);
            data_rvalid_o <= rd_done_i && (rd_beat_i.src == SRC_DCACHE);
            unc_rvalid_o  <= rd_done_i && (rd_beat_i.src == SRC_UNC);
            data_bvalid_o <= wr_done_i && !wr_uncached_i;
            unc_bvalid_o  <= wr_done_i && wr_uncached_i;
        end
    end

endmodule

// ==== verilog/cache_bus_bridge.sv ====
`timescale 1ns/1ps

module cache_bus_bridge (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inst_ren_i,
    input  logic [31:0]                   inst_addr_i,
    output logic                          inst_accept_o,
    output logic                          inst_rvalid_o,
    output logic [bridge_pkg::LINE_W-1:0] inst_rdata_o,
    input  logic                          data_ren_i,
    input  logic [31:0]                   data_raddr_i,
    output logic                          data_raccept_o,
    output logic                          data_rvalid_o,
    output logic [bridge_pkg::LINE_W-1:0] data_rdata_o,
    input  logic                          data_wen_i,
    input  logic [31:0]                   data_waddr_i,
    input  logic [bridge_pkg::LINE_W-1:0] data_wdata_i,
    output logic                          data_waccept_o,
    output logic                          data_bvalid_o,
    input  logic                          unc_ren_i,
    input  logic [31:0]                   unc_raddr_i,
    output logic                          unc_raccept_o,
    output logic                          unc_rvalid_o,
    output logic [bridge_pkg::BEAT_W-1:0] unc_rdata_o,
    input  logic                          unc_wen_i,
    input  logic [31:0]                   unc_waddr_i,
    input  logic [bridge_pkg::BEAT_W-1:0] unc_wdata_i,
    input  logic [3:0]                    unc_wstrb_i,
    output logic                          unc_waccept_o,
    output logic                          unc_bvalid_o,
    output logic                          bus_ren_o,
    output logic [31:0]                   bus_raddr_o,
    output logic [7:0]                    bus_rlen_o,
    input  logic                          bus_rvalid_i,
    input  logic [bridge_pkg::BEAT_W-1:0] bus_rdata_i,
    output logic                          bus_wen_o,
    output logic [31:0]                   bus_waddr_o,
    output logic [bridge_pkg::BEAT_W-1:0] bus_wdata_o,
    output logic [3:0]                    bus_wstrb_o,
    output logic [7:0]                    bus_wlen_o,
    output logic                          bus_wlast_o,
    input  logic                          bus_wresp_i
);
    import bridge_pkg::*;

    rd_desc_t rd_desc;
    wr_desc_t wr_desc;
    rd_beat_t rd_beat;
    logic     rd_busy;
    logic     rd_done;
    logic     wr_busy;
    logic     wr_done;

    req_decode u_req_decode (
        .clk            (clk),
        .rst            (rst),
        .inst_ren_i     (inst_ren_i),
        .inst_addr_i    (inst_addr_i),
        .data_ren_i     (data_ren_i),
        .data_raddr_i   (data_raddr_i),
        .data_wen_i     (data_wen_i),
        .data_waddr_i   (data_waddr_i),
        .data_wdata_i   (data_wdata_i),
        .unc_ren_i      (unc_ren_i),
        .unc_raddr_i    (unc_raddr_i),
        .unc_wen_i      (unc_wen_i),
        .unc_waddr_i    (unc_waddr_i),
        .unc_wdata_i    (unc_wdata_i),
        .unc_wstrb_i    (unc_wstrb_i),
        .rd_busy_i      (rd_busy),
        .rd_done_i      (rd_done),
        .wr_busy_i      (wr_busy),
        .wr_done_i      (wr_done),
        .inst_accept_o  (inst_accept_o),
        .data_raccept_o (data_raccept_o),
        .data_waccept_o (data_waccept_o),
        .unc_raccept_o  (unc_raccept_o),
        .unc_waccept_o  (unc_waccept_o),
        .rd_desc_o      (rd_desc),
        .wr_desc_o      (wr_desc)
    );

    read_burst_engine u_read_engine (
        .clk          (clk),
        .rst          (rst),
        .rd_desc_i    (rd_desc),
        .bus_rvalid_i (bus_rvalid_i),
        .bus_rdata_i  (bus_rdata_i),
        .rd_busy_o    (rd_busy),
        .rd_done_o    (rd_done),
        .rd_beat_o    (rd_beat),
        .bus_ren_o    (bus_ren_o),
        .bus_raddr_o  (bus_raddr_o),
        .bus_rlen_o   (bus_rlen_o)
    );

    write_burst_engine u_write_engine (
        .clk         (clk),
        .rst         (rst),
        .wr_desc_i   (wr_desc),
        .bus_wresp_i (bus_wresp_i),
        .wr_busy_o   (wr_busy),
        .wr_done_o   (wr_done),
        .bus_wen_o   (bus_wen_o),
        .bus_waddr_o (bus_waddr_o),
        .bus_wdata_o (bus_wdata_o),
        .bus_wstrb_o (bus_wstrb_o),
        .bus_wlen_o  (bus_wlen_o),
        .bus_wlast_o (bus_wlast_o)
    );

    line_assembler u_line_assembler (
        .clk           (clk),
        .rst           (rst),
        .rd_beat_i     (rd_beat),
        .rd_done_i     (rd_done),
        .wr_done_i     (wr_done),
        .wr_uncached_i (wr_desc.uncached),
        .inst_rvalid_o (inst_rvalid_o),
        .inst_rdata_o  (inst_rdata_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .unc_rvalid_o  (unc_rvalid_o),
        .unc_rdata_o   (unc_rdata_o),
        .data_bvalid_o (data_bvalid_o),
        .unc_bvalid_o  (unc_bvalid_o)
    );

endmodule

// ==== testbench/tb_cache_bus_bridge.sv ====
`timescale 1ns/1ps

module tb_cache_bus_bridge;
    import bridge_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 200;

    logic                clk;
    logic                rst;
    logic                inst_ren_i;
    logic [31:0]         inst_addr_i;
    logic                inst_accept_o;
    logic                inst_rvalid_o;
    logic [LINE_W-1:0]   inst_rdata_o;
    logic                data_ren_i;
    logic [31:0]         data_raddr_i;
    logic                data_raccept_o;
    logic                data_rvalid_o;
    logic [LINE_W-1:0]   data_rdata_o;
    logic                data_wen_i;
    logic [31:0]         data_waddr_i;
    logic [LINE_W-1:0]   data_wdata_i;
    logic                data_waccept_o;
    logic                data_bvalid_o;
    logic                unc_ren_i;
    logic [31:0]         unc_raddr_i;
    logic                unc_raccept_o;
    logic                unc_rvalid_o;
    logic [BEAT_W-1:0]   unc_rdata_o;
    logic                unc_wen_i;
    logic [31:0]         unc_waddr_i;
    logic [BEAT_W-1:0]   unc_wdata_i;
    logic [3:0]          unc_wstrb_i;
    logic                unc_waccept_o;
    logic                unc_bvalid_o;
    logic                bus_ren_o;
    logic [31:0]         bus_raddr_o;
    logic [7:0]          bus_rlen_o;
    logic                bus_rvalid_i;
    logic [BEAT_W-1:0]   bus_rdata_i;
    logic                bus_wen_o;
    logic [31:0]         bus_waddr_o;
    logic [BEAT_W-1:0]   bus_wdata_o;
    logic [3:0]          bus_wstrb_o;
    logic [7:0]          bus_wlen_o;
    logic                bus_wlast_o;
    logic                bus_wresp_i;

    logic [BEAT_W-1:0] mem [MEM_WORDS];
    logic [BEAT_W-1:0] shadow [MEM_WORDS];
    integer            seed;
    int                errors;
    int                i;
    int                rd_base;
    int                rd_len;
    int                rd_b;
    int                wr_base;
    int                wr_len;
    int                wr_b;
    int                wr_j;
    int                rd_issued [3];
    int                rd_done_cnt [3];
    int                wr_issued [2];
    int                wr_done_cnt [2];
    int                rd_log [$];
    int                wr_log [$];
    logic [31:0]       inst_q [$];
    logic [31:0]       data_q [$];
    logic [31:0]       unc_q [$];
    logic [31:0]       rnd;
    logic [31:0]       r_addr;
    int                r_port;

    cache_bus_bridge uut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // expected line (or word in the low bits) from the shadow memory
    function automatic logic [LINE_W-1:0] mem_line(input logic [31:0] addr, input logic line);
        logic [LINE_W-1:0] r;
        int                base;
        int                w;
        r = '0;
        if (line)
        begin
            base = {addr[11:5], 3'b000};
            for (w = 0; w < LINE_BEATS; w++)
                r[w*BEAT_W +: BEAT_W] = shadow[base + w];
        end
        else
            r[BEAT_W-1:0] = shadow[addr[11:2]];
        return r;
    endfunction

    function automatic logic [LINE_W-1:0] rand_line();
        logic [LINE_W-1:0] r;
        int                w;
        for (w = 0; w < LINE_BEATS; w++)
            r[w*BEAT_W +: BEAT_W] = $random(seed);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic shadow_write(input logic unc, input logic [31:0] addr,
                                input logic [LINE_W-1:0] data, input logic [3:0] strb);
        int base;
        int j;
        if (unc)
        begin
            base = addr[11:2];
            for (j = 0; j < 4; j++)
                if (strb[j])
                    shadow[base][j*8 +: 8] = data[j*8 +: 8];
        end
        else
        begin
            base = {addr[11:5], 3'b000};
            for (j = 0; j < LINE_BEATS; j++)
                shadow[base + j] = data[j*BEAT_W +: BEAT_W];
        end
    endtask

    task automatic set_read_req(input int port, input logic on, input logic [31:0] addr);
        case (port)
            0:
            begin
                inst_ren_i  = on;
                inst_addr_i = addr;
            end
            1:
            begin
                data_ren_i   = on;
                data_raddr_i = addr;
            end
            default:
            begin
                unc_ren_i   = on;
                unc_raddr_i = addr;
            end
        endcase
    endtask

    function automatic logic read_accepted(input int port);
        return (port == 0) ? inst_accept_o : (port == 1) ? data_raccept_o : unc_raccept_o;
    endfunction

    function automatic logic read_completed(input int port);
        return (port == 0) ? inst_rvalid_o : (port == 1) ? data_rvalid_o : unc_rvalid_o;
    endfunction

    task automatic issue_read(input int port, input logic [31:0] addr);
        int   t;
        logic seen;
        @(negedge clk);
        set_read_req(port, 1'b1, addr);
        seen = 1'b0;
        t = 0;
        while (!seen && t < TIMEOUT)
        begin
            @(posedge clk);
            seen = read_accepted(port);
            t++;
        end
        @(negedge clk);
        set_read_req(port, 1'b0, addr);
        if (!seen)
        begin
            errors++;
            $display("read request on port %0d for %h was never accepted", port, addr);
        end
        else
        begin
            case (port)
                0: inst_q.push_back(addr);
                1: data_q.push_back(addr);
                default: unc_q.push_back(addr);
            endcase
            rd_issued[port]++;
            seen = 1'b0;
            t = 0;
            while (!seen && t < TIMEOUT)
            begin
                @(posedge clk);
                seen = read_completed(port);
                t++;
            end
            if (!seen)
            begin
                errors++;
                $display("read on port %0d for %h never completed", port, addr);
            end
        end
    endtask

    task automatic issue_write(input logic unc, input logic [31:0] addr,
                               input logic [LINE_W-1:0] data, input logic [3:0] strb);
        int   t;
        logic seen;
        @(negedge clk);
        if (unc)
        begin
            unc_wen_i   = 1'b1;
            unc_waddr_i = addr;
            unc_wdata_i = data[BEAT_W-1:0];
            unc_wstrb_i = strb;
        end
        else
        begin
            data_wen_i   = 1'b1;
            data_waddr_i = addr;
            data_wdata_i = data;
        end
        seen = 1'b0;
        t = 0;
        while (!seen && t < TIMEOUT)
        begin
            @(posedge clk);
            seen = unc ? unc_waccept_o : data_waccept_o;
            t++;
        end
        @(negedge clk);
        if (unc)
            unc_wen_i = 1'b0;
        else
            data_wen_i = 1'b0;
        if (!seen)
        begin
            errors++;
            $display("write request (uncached %0d) for %h was never accepted", unc, addr);
        end
        else
        begin
            shadow_write(unc, addr, data, strb);
            wr_issued[unc]++;
            seen = 1'b0;
            t = 0;
            while (!seen && t < TIMEOUT)
            begin
                @(posedge clk);
                seen = unc ? unc_bvalid_o : data_bvalid_o;
                t++;
            end
            if (!seen)
            begin
                errors++;
                $display("write (uncached %0d) for %h never completed", unc, addr);
            end
        end
    endtask

    task automatic compare_read(input int port, input logic [LINE_W-1:0] got);
        logic [31:0] addr;
        int          pending;
        pending = (port == 0) ? inst_q.size() : (port == 1) ? data_q.size() : unc_q.size();
        rd_done_cnt[port]++;
        if (pending == 0)
        begin
            errors++;
            $display("read port %0d completed with no request outstanding", port);
        end
        else
        begin
            case (port)
                0: addr = inst_q.pop_front();
                1: addr = data_q.pop_front();
                default: addr = unc_q.pop_front();
            endcase
            case (port)
                0: check_value("inst_rdata_o", got, mem_line(addr, 1'b1));
                1: check_value("data_rdata_o", got, mem_line(addr, 1'b1));
                default: check_value("unc_rdata_o", got, mem_line(addr, 1'b0));
            endcase
        end
    endtask

    // checker: accept order and completion data
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (unc_raccept_o)
                rd_log.push_back(2);
            if (data_raccept_o)
                rd_log.push_back(1);
            if (inst_accept_o)
                rd_log.push_back(0);
            if (unc_waccept_o)
                wr_log.push_back(1);
            if (data_waccept_o)
                wr_log.push_back(0);
            if (inst_rvalid_o)
                compare_read(0, inst_rdata_o);
            if (data_rvalid_o)
                compare_read(1, data_rdata_o);
            if (unc_rvalid_o)
                compare_read(2, LINE_W'(unc_rdata_o));
            if (data_bvalid_o)
                wr_done_cnt[0]++;
            if (unc_bvalid_o)
                wr_done_cnt[1]++;
        end
    end

    // memory read side, 0 to 3 idle cycles before each beat
    always
    begin
        @(negedge clk);
        if (bus_ren_o)
        begin
            rd_base = bus_raddr_o[11:2];
            rd_len  = bus_rlen_o;
            for (rd_b = 0; rd_b <= rd_len; rd_b++)
            begin
                repeat ({$random(seed)} % 4) @(negedge clk);
                bus_rvalid_i = 1'b1;
                bus_rdata_i  = mem[(rd_base + rd_b) % MEM_WORDS];
                @(negedge clk);
                bus_rvalid_i = 1'b0;
            end
        end
    end

    // memory write side
    always
    begin
        @(negedge clk);
        if (bus_wen_o)
        begin
            wr_base = bus_waddr_o[11:2];
            wr_len  = bus_wlen_o;
            for (wr_b = 0; wr_b <= wr_len; wr_b++)
            begin
                repeat ({$random(seed)} % 4) @(negedge clk);
                // only the final beat of a burst carries wlast
                check_value("bus_wlast_o", bus_wlast_o, wr_b == wr_len);
                for (wr_j = 0; wr_j < 4; wr_j++)
                    if (bus_wstrb_o[wr_j])
                        mem[(wr_base + wr_b) % MEM_WORDS][wr_j*8 +: 8] = bus_wdata_o[wr_j*8 +: 8];
                bus_wresp_i = 1'b1;
                @(negedge clk);
                bus_wresp_i = 1'b0;
            end
        end
    end

    initial
    begin
        seed = 32'h58ce_408b;
        errors = 0;
        rst = 1'b1;
        inst_ren_i = 1'b0;
        inst_addr_i = '0;
        data_ren_i = 1'b0;
        data_raddr_i = '0;
        data_wen_i = 1'b0;
        data_waddr_i = '0;
        data_wdata_i = '0;
        unc_ren_i = 1'b0;
        unc_raddr_i = '0;
        unc_wen_i = 1'b0;
        unc_waddr_i = '0;
        unc_wdata_i = '0;
        unc_wstrb_i = '0;
        bus_rvalid_i = 1'b0;
        bus_rdata_i = '0;
        bus_wresp_i = 1'b0;
        for (i = 0; i < 3; i++)
        begin
            rd_issued[i] = 0;
            rd_done_cnt[i] = 0;
        end
        for (i = 0; i < 2; i++)
        begin
            wr_issued[i] = 0;
            wr_done_cnt[i] = 0;
        end
        for (i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] = $random(seed);
            shadow[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // icache refill from an unaligned address
        issue_read(0, 32'h0000_0124);

        // dcache refill, writeback, then refill of the same line
        issue_read(1, 32'h0000_0340);
        issue_write(1'b0, 32'h0000_0340, rand_line(), 4'hf);
        issue_read(1, 32'h0000_0344);

        // partial strobes on an uncached word
        issue_write(1'b1, 32'h0000_0508, rand_line(), 4'b0101);
        issue_read(2, 32'h0000_0508);

        @(negedge clk);
        rd_log.delete();
        wr_log.delete();
        fork
            issue_read(0, 32'h0000_0600);
            issue_read(1, 32'h0000_0700);
            issue_read(2, 32'h0000_0614);
            issue_write(1'b0, 32'h0000_0a00, rand_line(), 4'hf);
            issue_write(1'b1, 32'h0000_0b04, rand_line(), 4'b1100);
        join
        check_value("read accept count", rd_log.size(), 3);
        if (rd_log.size() == 3)
            check_value("read accept order", rd_log[0] * 16 + rd_log[1] * 4 + rd_log[2], 36);
        check_value("write accept count", wr_log.size(), 2);
        if (wr_log.size() == 2)
            check_value("write accept order", wr_log[0] * 4 + wr_log[1], 4);

        // overlapping read and write, write line always differs from read line
        for (i = 0; i < 40; i++)
        begin
            rnd = $random(seed);
            r_addr = $random(seed) & 32'h0000_0ffc;
            r_port = rnd[9:8] % 3;
            fork
                issue_read(r_port, r_addr);
                issue_write(rnd[0], r_addr ^ 32'h0000_0800, rand_line(),
                            rnd[0] ? rnd[7:4] : 4'hf);
            join
        end

        @(negedge clk);
        for (i = 0; i < 3; i++)
            check_value("read completions", rd_done_cnt[i], rd_issued[i]);
        for (i = 0; i < 2; i++)
            check_value("write completions", wr_done_cnt[i], wr_issued[i]);
        check_value("pending reads", inst_q.size() + data_q.size() + unc_q.size(), 0);
        // every write landed in memory with its strobes
        for (i = 0; i < MEM_WORDS; i++)
            check_value("mem", mem[i], shadow[i]);
        $display("finished: %0d reads, %0d writes, %0d errors",
                 rd_issued[0] + rd_issued[1] + rd_issued[2], wr_issued[0] + wr_issued[1], errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/bridge_pkg.sv
verilog/req_decode.sv
verilog/read_burst_engine.sv
verilog/write_burst_engine.sv
verilog/line_assembler.sv
verilog/cache_bus_bridge.sv
testbench/tb_cache_bus_bridge.sv

// ==== Bender.yml ====
package:
  name: cache_bus_bridge

sources:
  - files:
      - verilog/bridge_pkg.sv
      - verilog/req_decode.sv
      - verilog/read_burst_engine.sv
      - verilog/write_burst_engine.sv
      - verilog/line_assembler.sv
      - verilog/cache_bus_bridge.sv
  - target: test
    files:
      - testbench/tb_cache_bus_bridge.sv
